// ==== include/pad_params.svh ====
// ========================================
// pad mask stage parameters
// kernel limit, datapath count, field widths
// and the bit layout of the beat tag word
// ========================================
`ifndef PAD_PARAMS_SVH
`define PAD_PARAMS_SVH

`define KERNEL_W_MAX   7 // widest odd kernel the lookup logic is built for
`define MEMBERS        8 // parallel datapaths that each get a mask bit

`define BITS_KERNEL_W  3 // holds kernel width and clr codes up to 7
`define BITS_COLS      8 // up to 255 columns per row
`define BITS_CIN       6 // up to 63 input channels per column

// tag word layout, kw-1 sits in the low bits
`define I_KERNEL_W_1   0
`define I_IS_CONFIG    3 // first beat of a row, carries no column
`define I_IS_CIN_LAST  4 // last channel of the current column
`define I_IS_COLS_1_K2 5 // column equals cols-1-kw/2
`define TUSER_WIDTH    6

`endif

// ==== rtl/pad_cfg_apb.sv ====
// ========================================
// pad configuration registers on APB
// holds kernel width, columns and channels,
// launches a row and reports busy
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "pad_params.svh"

module pad_cfg_apb import pad_pkg::*; (
    input  wire logic        aclk,
    input  wire logic        reset,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [11:0] paddr,
    input  wire logic [31:0] pwdata,
    input  wire logic        done,    // row finished, clears busy
    output logic      [31:0] prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             start,   // one cycle, same cycle as the access phase
    output kw_t              kw,
    output col_t             cols,
    output cin_t             cins
);

    logic access;  // access phase of any transfer
    logic mapped;  // address hits one of the four registers
    logic bad;     // legal address but the write must be refused
    logic wr_ok;   // write that actually lands
    logic busy;

    assign access  = psel & penable;
    assign pready  = access;                     // never wait states
    assign pslverr = access & (!mapped | bad);
    assign wr_ok   = access & pwrite & mapped & !bad;
    assign start   = wr_ok & (paddr == 12'h00c);

    always_comb begin
        mapped = 1'b1;
        bad    = 1'b0;
        prdata = '0;
        case (paddr)
            12'h000: begin
                prdata = 32'(kw);
                bad    = pwrite & (!pwdata[0] | (pwdata > `KERNEL_W_MAX)); // even or too wide
            end
            12'h004: prdata = 32'(cols);
            12'h008: prdata = 32'(cins);
            12'h00c: begin
                prdata = 32'(busy);
                bad    = pwrite & busy; // no second start while a row runs
            end
            default: mapped = 1'b0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            kw   <= kw_t'(1);  // smallest legal kernel
            cols <= col_t'(1);
            cins <= cin_t'(1);
            busy <= 1'b0;
        end else begin
            if (wr_ok && paddr == 12'h000) kw   <= pwdata[`BITS_KERNEL_W-1:0];
            if (wr_ok && paddr == 12'h004) cols <= pwdata[`BITS_COLS-1:0];
            if (wr_ok && paddr == 12'h008) cins <= pwdata[`BITS_CIN-1:0];
            if (start) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0; // sequencer has sent its last beat
            end
        end
    end

    // the sequencer only reports the end of a row that was launched from here
    a_done_busy: assert property (@(posedge aclk) disable iff (reset)
        done |-> busy);

endmodule

`default_nettype wire

// ==== rtl/pad_col_seq.sv ====
// ========================================
// pad row sequencer
// emits a config beat, then one beat per
// column and channel with its tag bits
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "pad_params.svh"

module pad_col_seq import pad_pkg::*; (
    input  wire logic aclk,
    input  wire logic reset,
    input  wire logic start,
    input  wire kw_t  kw,
    input  wire col_t cols,
    input  wire cin_t cins,
    input  wire logic clken,      // output buffer has room
    output logic      beat_valid,
    output tuser_t    beat_user,
    output logic      done
);

    logic                is_cfg;     // current beat is the config beat
    col_t                col;        // column of the current beat
    cin_t                cin;        // channel of the current beat
    kw_t                 kw_r;       // row settings latched at start
    col_t                cols_r;
    cin_t                cins_r;
    logic                xfer;       // beat accepted this cycle
    logic                cin_last;
    logic                col_last;
    logic [`BITS_COLS:0] col_k2;     // col + kw/2, one bit wider so it cannot wrap

    assign xfer     = beat_valid & clken;
    assign cin_last = (cin == cin_t'(cins_r - 1'b1));
    assign col_last = (col == col_t'(cols_r - 1'b1));
    assign col_k2   = {1'b0, col} + (`BITS_COLS+1)'(kw_r >> 1);

    always_comb begin
        beat_user = '0;
        beat_user[`I_KERNEL_W_1 +: `BITS_KERNEL_W] = kw_r - 1'b1; // kw-1 rides on every beat
        beat_user[`I_IS_CONFIG]    = is_cfg;
        beat_user[`I_IS_CIN_LAST]  = !is_cfg & cin_last;
        // marks the column where the right padding region starts to build up
        beat_user[`I_IS_COLS_1_K2] = !is_cfg & ((kw_r >> 1) != '0) &
                                     (col_k2 == ({1'b0, cols_r} - 1'b1));
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            beat_valid <= 1'b0;
            is_cfg     <= 1'b0;
            done       <= 1'b0;
            col        <= '0;
            cin        <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                beat_valid <= 1'b1; // config beat goes out the next cycle
                is_cfg     <= 1'b1;
            end else if (xfer) begin
                if (is_cfg) begin
                    is_cfg <= 1'b0;
                    col    <= '0;
                    cin    <= '0;
                end else if (cin_last) begin
                    cin <= '0;
                    if (col_last) begin
                        beat_valid <= 1'b0; // row complete
                        done       <= 1'b1;
                    end else begin
                        col <= col + 1'b1;
                    end
                end else begin
                    cin <= cin + 1'b1;
                end
            end
        end
    end

    // settings are payload and only sampled when a row starts
    always_ff @(posedge aclk) begin
        if (start) begin
            kw_r   <= kw;
            cols_r <= cols;
            cins_r <= cins;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pad_filter.sv ====
// ========================================
// pad filter
// tracks the start and end columns of a row
// and looks up full mask, partial mask and
// the center/left/right code per datapath
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "pad_params.svh"

module pad_filter import pad_pkg::*; #(
    parameter int KERNEL_W_MAX_P = `KERNEL_W_MAX
) (
    input  wire logic           aclk,
    input  wire logic           reset,
    input  wire logic           clken,
    input  wire logic           beat_valid,
    input  wire tuser_t         beat_user,
    output logic [`MEMBERS-1:0] mask_full,
    output logic [`MEMBERS-1:1] mask_partial,  // member 0 never carries a partial sum
    output clr_t [`MEMBERS-1:0] clr
);

    localparam int KW2_MAX = KERNEL_W_MAX_P / 2; // 7 -> 3, 5 -> 2, 3 -> 1

    logic [`BITS_KERNEL_W-2:0] kw2;         // kw/2, the upper bits of kw-1
    logic                      is_config;
    logic                      reg_clken;   // registers move once per column
    logic [KW2_MAX:1]          col_start_q; // bit i set during column i-1
    logic [KW2_MAX:1]          col_end_q;   // bit i set during column cols-1-kw2+i
    logic [KW2_MAX:1]          col_start_in;
    logic [KW2_MAX:1]          col_end_in;
    logic [KW2_MAX:0]          col_end;     // bit 0 is the current beat's own flag
    clr_t                      clr_left_in;
    clr_t                      clr_left_q;
    clr_t                      clr_right;
    clr_t                      clr_code;

    assign kw2       = beat_user[`I_KERNEL_W_1+1 +: `BITS_KERNEL_W-1];
    assign is_config = beat_user[`I_IS_CONFIG];
    assign reg_clken = clken & beat_valid & (beat_user[`I_IS_CIN_LAST] | is_config);
    assign col_end   = {col_end_q, beat_user[`I_IS_COLS_1_K2] & (kw2 != '0)};

    always_comb begin
        // the config beat seeds the start chain, every column end shifts it up
        col_start_in = col_start_q << 1;
        col_end_in   = col_end_q << 1;
        col_end_in[1] = beat_user[`I_IS_COLS_1_K2] & (kw2 != '0);
        if (is_config) begin
            col_start_in    = '0;
            col_start_in[1] = (kw2 != '0);
            col_end_in      = '0;   // drop anything left over from the last row
        end
        // left code counts down towards the center, 2k-1 in column 0 and 1 in column k-1
        clr_left_in = '0;
        for (int i = 1; i <= KW2_MAX; i++) begin
            if (col_start_in[i] && i <= int'(kw2)) begin
                clr_left_in = clr_t'(2 * (int'(kw2) - i) + 1);
            end
        end
        // right code counts up, 2 at the first padded column and 2k at the last
        clr_right = '0;
        for (int i = 1; i <= KW2_MAX; i++) begin
            if (col_end_q[i]) clr_right = clr_t'(2 * i);
        end
        clr_code = (clr_right != '0) ? clr_right : clr_left_q;
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            col_start_q <= '0;
            col_end_q   <= '0;
            clr_left_q  <= clr_t'(1);
        end else if (reg_clken) begin
            col_start_q <= col_start_in;
            col_end_q   <= col_end_in;
            clr_left_q  <= clr_left_in;
        end
    end

    for (genvar m = 0; m < `MEMBERS; m++) begin : g_full
        logic [KW2_MAX:0] allow;
        assign allow[0] = 1'b1;            // kw = 1 needs no padding at all
        for (genvar k2 = 1; k2 <= KW2_MAX; k2++) begin : g_kw
            localparam int KW        = 2 * k2 + 1;
            localparam bit FULL_DP   = (m % KW) == KW - 1;             // holds a finished sum
            localparam bit UNUSED    = m >= (`MEMBERS / KW) * KW;      // no whole kernel fits
            localparam bit MALFORMED = (m % KW) < k2;                  // sum is garbage at row end
            assign allow[k2] = (FULL_DP && !(|col_start_q[k2:1])) ||
                               (col_end_q[k2] && !MALFORMED && !UNUSED);
        end
        assign mask_full[m] = allow[kw2] | is_config;
        assign clr[m]       = clr_code;   // every member sees the same column position
    end

    for (genvar m = 1; m < `MEMBERS; m++) begin : g_partial
        logic [KW2_MAX:0] stop;
        assign stop[0] = 1'b1;
        for (genvar k2 = 1; k2 <= KW2_MAX; k2++) begin : g_kw
            localparam int KW     = 2 * k2 + 1;
            localparam int J      = m % KW;
            localparam bit UNUSED = m >= (`MEMBERS / KW) * KW;
            if (J > k2) begin : g_hi
                assign stop[k2] = col_end[k2] || UNUSED;        // only the last column is cut
            end else begin : g_lo
                assign stop[k2] = (|col_end[k2:J]) || UNUSED;   // the blocking triangle
            end
        end
        assign mask_partial[m] = !stop[kw2];
    end

    // kernel width comes from the APB block through the sequencer
    a_kw_odd: assert property (@(posedge aclk) disable iff (reset)
        beat_valid |-> !beat_user[`I_KERNEL_W_1] && (kw2 <= KW2_MAX));

endmodule

`default_nettype wire

// ==== rtl/pad_out_buf.sv ====
// ========================================
// pad output buffer
// two entries of masks and tags, stalls the
// sequencer and filter through clken
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "pad_params.svh"

module pad_out_buf import pad_pkg::*; (
    input  wire logic               aclk,
    input  wire logic               reset,
    input  wire logic               in_valid,
    input  wire logic [`MEMBERS-1:0] mask_full,
    input  wire logic [`MEMBERS-1:1] mask_partial,
    input  wire clr_t [`MEMBERS-1:0] clr,
    input  wire tuser_t             user,
    input  wire logic               out_ready,
    output logic                    clken,            // room for one more beat
    output logic                    out_valid,
    output logic [`MEMBERS-1:0]     out_mask_full,
    output logic [`MEMBERS-1:1]     out_mask_partial,
    output clr_t [`MEMBERS-1:0]     out_clr,
    output logic                    out_is_config,
    output logic                    out_cin_last
);

    logic [`MEMBERS-1:0] full_mem [2];
    logic [`MEMBERS-1:1] part_mem [2];
    clr_t [`MEMBERS-1:0] clr_mem  [2];
    logic                cfg_mem  [2];
    logic                last_mem [2];
    logic [1:0]          count;
    logic                wr_ptr;
    logic                rd_ptr;
    logic                wr;
    logic                rd;

    assign clken     = (count != 2'd2);
    assign wr        = in_valid & clken;
    assign out_valid = (count != 2'd0);
    assign rd        = out_valid & out_ready;

    assign out_mask_full    = full_mem[rd_ptr]; // head entry stays put until taken
    assign out_mask_partial = part_mem[rd_ptr];
    assign out_clr          = clr_mem[rd_ptr];
    assign out_is_config    = cfg_mem[rd_ptr];
    assign out_cin_last     = last_mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (reset) begin
            count  <= '0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            if (wr) wr_ptr <= ~wr_ptr;
            if (rd) rd_ptr <= ~rd_ptr;
            count <= count + 2'(wr) - 2'(rd);
        end
    end

    always_ff @(posedge aclk) begin
        if (wr) begin
            full_mem[wr_ptr] <= mask_full;
            part_mem[wr_ptr] <= mask_partial;
            clr_mem[wr_ptr]  <= clr;
            cfg_mem[wr_ptr]  <= user[`I_IS_CONFIG];
            last_mem[wr_ptr] <= user[`I_IS_CIN_LAST];
        end
    end

    // a beat refused by the full buffer must still be offered unchanged next cycle
    a_no_full_write: assert property (@(posedge aclk) disable iff (reset)
        in_valid && !clken |=> in_valid && $stable(user));

endmodule

`default_nettype wire

// ==== rtl/pad_pkg.sv ====
// ========================================
// pad mask stage types
// shared by the register block, sequencer,
// filter and output buffer
// ========================================
`default_nettype none

`include "pad_params.svh"

package pad_pkg;

    typedef logic [`BITS_KERNEL_W-1:0] kw_t;   // kernel width, always odd
    typedef logic [`BITS_COLS-1:0]     col_t;  // column count or column index
    typedef logic [`BITS_CIN-1:0]      cin_t;  // channel count or channel index

    // 0 is center, odd codes are left edge columns, even nonzero codes are right edge
    typedef logic [`BITS_KERNEL_W-1:0] clr_t;

    typedef logic [`TUSER_WIDTH-1:0]   tuser_t; // tag word travelling with every beat

endpackage

`default_nettype wire

// ==== rtl/pad_top.sv ====
// ========================================
// pad mask stage top level
// APB config, row sequencer, pad filter
// and output buffer in a chain
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "pad_params.svh"

module pad_top import pad_pkg::*; (
    input  wire logic               aclk,
    input  wire logic               reset,
    input  wire logic               psel,
    input  wire logic               penable,
    input  wire logic               pwrite,
    input  wire logic [11:0]        paddr,
    input  wire logic [31:0]        pwdata,
    output logic      [31:0]        prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  wire logic               out_ready,
    output logic                    out_valid,
    output logic [`MEMBERS-1:0]     out_mask_full,
    output logic [`MEMBERS-1:1]     out_mask_partial,
    output clr_t [`MEMBERS-1:0]     out_clr,
    output logic                    out_is_config,
    output logic                    out_cin_last
);

    logic                start;
    logic                done;
    kw_t                 kw;
    col_t                cols;
    cin_t                cins;
    logic                beat_valid;
    tuser_t              beat_user;
    logic                clken;        // shared stall for sequencer and filter
    logic [`MEMBERS-1:0] mask_full;
    logic [`MEMBERS-1:1] mask_partial;
    clr_t [`MEMBERS-1:0] clr;

    pad_cfg_apb u_cfg (
        .aclk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
        .done, .prdata, .pready, .pslverr, .start, .kw, .cols, .cins
    );

    pad_col_seq u_seq (
        .aclk, .reset, .start, .kw, .cols, .cins, .clken,
        .beat_valid, .beat_user, .done
    );

    pad_filter #(.KERNEL_W_MAX_P(`KERNEL_W_MAX)) u_filter (
        .aclk, .reset, .clken, .beat_valid, .beat_user,
        .mask_full, .mask_partial, .clr
    );

    pad_out_buf u_buf (
        .aclk, .reset, .in_valid(beat_valid), .mask_full, .mask_partial, .clr,
        .user(beat_user), .out_ready, .clken, .out_valid, .out_mask_full,
        .out_mask_partial, .out_clr, .out_is_config, .out_cin_last
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# compile the pad mask stage testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module pad_tb -Mdir obj_dir -o pad_sim &&
./obj_dir/pad_sim | tee /dev/stderr | grep "All tests passed" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== sim.f ====
+incdir+include
rtl/pad_pkg.sv
rtl/pad_cfg_apb.sv
rtl/pad_col_seq.sv
rtl/pad_filter.sv
rtl/pad_out_buf.sv
rtl/pad_top.sv
sim/pad_tb.sv

// ==== sim/pad_tb.sv ====
// ========================================
// pad mask stage testbench
// APB register checks, directed rows against
// a mask model and random out_ready stalls
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "pad_params.svh"

module pad_tb import pad_pkg::*; ();

    localparam int TOTAL_BEATS     = 9 + 9 + 7 + 31 + 31 + 31 + 17; // outputs of all rows
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 4 + 200;

    logic                aclk;
    logic                reset;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [11:0]         paddr;
    logic [31:0]         pwdata;
    logic [31:0]         prdata;
    logic                pready;
    logic                pslverr;
    logic                out_ready;
    logic                out_valid;
    logic [`MEMBERS-1:0] out_mask_full;
    logic [`MEMBERS-1:1] out_mask_partial;
    clr_t [`MEMBERS-1:0] out_clr;
    logic                out_is_config;
    logic                out_cin_last;

    logic [`MEMBERS-1:0] exp_full[$];
    logic [`MEMBERS-1:0] exp_part[$];    // bit 0 is always zero
    logic                exp_cfg[$];
    logic                exp_last[$];
    int                  exp_cls[$];     // -1 where no clr code is defined
    logic [`MEMBERS-1:0] got_full[$];
    logic [`MEMBERS-1:0] got_part[$];
    clr_t [`MEMBERS-1:0] got_clr[$];
    logic                got_cfg[$];
    logic                got_last[$];
    int                  row_base;       // index of the current row's first output
    int                  value_errors = 0;
    int                  other_errors = 0;
    logic                stall_en = 1'b0;
    logic [31:0]         lfsr = 32'hc144;

    pad_top dut0 (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    // out_ready follows the lfsr while stalls are on, otherwise it stays high
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge aclk);
            out_ready <= stall_en ? next_bit() : 1'b1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h80200003 : 32'h0); // galois form, one step per bit
        return b;
    endfunction

    function automatic logic [`MEMBERS-1:0] model_full(input int kw, w, c);
        logic [`MEMBERS-1:0] r;
        int                  j;
        for (int m = 0; m < `MEMBERS; m++) begin
            j = m % kw;
            r[m] = (kw == 1) || (j == kw - 1 && c >= kw / 2) ||
                   (c == w - 1 && j >= kw / 2 && m < (`MEMBERS / kw) * kw);
        end
        return r;
    endfunction

    function automatic logic [`MEMBERS-1:0] model_part(input int kw, w, c);
        logic [`MEMBERS-1:0] r;
        int                  j;
        r = '0;
        for (int m = 1; m < `MEMBERS; m++) begin
            j = m % kw;
            if (kw > 1 && m < (`MEMBERS / kw) * kw)   // unused members stay zero
                r[m] = (j <= kw / 2) ? (c < w - 1 - kw / 2 + j) : (c != w - 1);
        end
        return r;
    endfunction

    // left padding covers the first kw/2 columns and right padding the last kw/2
    function automatic int model_cls(input int kw, w, c);
        if (kw == 1) return -1;
        if (c >= w - kw / 2) return 2;
        return (c < kw / 2) ? 1 : 0;
    endfunction

    task automatic check_mask(input string name, input logic [`MEMBERS-1:0] got, exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_apb(input string name, input logic [31:0] got, exp);
        if (got !== exp) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_clr(input string name, input clr_t got, input int cls);
        int got_cls;
        got_cls = (got == '0) ? 0 : (got[0] ? 1 : 2);  // center, left, right
        if (got_cls != cls) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %0d (class %0d) expected class %0d",
                     $time, name, got, got_cls, cls);
        end
    endtask

    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata,
                              output logic err);
        @(posedge aclk);
        psel    <= 1'b1;  // setup phase
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge aclk);
        penable <= 1'b1;
        @(negedge aclk);  // middle of the access phase
        check_bit("pready", pready, 1'b1);
        rdata = prdata;
        err   = pslverr;
        @(posedge aclk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input int data, input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, 32'(data), rdata, err);
        check_bit($sformatf("pslverr on write to %h", addr), err, exp_err);
    endtask

    task automatic apb_read(input logic [11:0] addr, input int exp);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, '0, rdata, err);
        check_bit($sformatf("pslverr on read of %h", addr), err, 1'b0);
        check_apb($sformatf("prdata at %h", addr), rdata, 32'(exp));
    endtask

    task automatic wait_idle();
        logic [31:0] rdata;
        logic        err;
        rdata = 32'd1;
        for (int tries = 0; tries < 20 && rdata != 32'd0; tries++)
            apb_access(1'b0, 12'h00c, '0, rdata, err);
        if (rdata != 32'd0) begin
            other_errors++;
            $display("busy did not clear after the row at %0t", $time);
        end
    endtask

    // records every transfer and checks that a stalled head entry holds still
    task automatic collect();
        logic                held;
        logic [`MEMBERS-1:0] held_full;
        logic [`MEMBERS-1:0] held_part;
        held = 1'b0;
        forever begin
            @(negedge aclk);
            if (held) begin
                check_bit("out_valid while stalled", out_valid, 1'b1);
                check_mask("out_mask_full while stalled", out_mask_full, held_full);
                check_mask("out_mask_partial while stalled", {out_mask_partial, 1'b0}, held_part);
            end
            held      = out_valid && !out_ready;
            held_full = out_mask_full;
            held_part = {out_mask_partial, 1'b0};
            if (out_valid && out_ready) begin  // transfers on the coming edge
                got_full.push_back(out_mask_full);
                got_part.push_back({out_mask_partial, 1'b0});
                got_clr.push_back(out_clr);
                got_cfg.push_back(out_is_config);
                got_last.push_back(out_cin_last);
            end
        end
    endtask

    task automatic prepare_row(input int kw, w, cins);
        exp_full.delete();
        exp_part.delete();
        exp_cfg.delete();
        exp_last.delete();
        exp_cls.delete();
        row_base = got_full.size();
        exp_full.push_back({`MEMBERS{1'b1}});  // config beat
        exp_part.push_back('0);
        exp_cfg.push_back(1'b1);
        exp_last.push_back(1'b0);
        exp_cls.push_back(-1);
        for (int c = 0; c < w; c++) begin
            for (int i = 0; i < cins; i++) begin
                exp_full.push_back(model_full(kw, w, c));
                exp_part.push_back(model_part(kw, w, c));
                exp_cls.push_back(model_cls(kw, w, c));
                exp_cfg.push_back(1'b0);
                exp_last.push_back(i == cins - 1);
            end
        end
        apb_write(12'h000, kw, 1'b0);
        apb_write(12'h004, w, 1'b0);
        apb_write(12'h008, cins, 1'b0);
    endtask

    task automatic finish_row(input int kw);
        int n;
        int cycles;
        int g;
        n = exp_full.size();
        cycles = 0;
        while (got_full.size() < row_base + n && cycles < n * 4 + 50) begin
            @(posedge aclk);
            cycles++;
        end
        stall_en = 1'b0;
        wait_idle();
        repeat (4) @(posedge aclk);  // room for any stray extra output
        if (got_full.size() != row_base + n) begin
            other_errors++;
            $display("row with kw=%0d gave %0d outputs, expected %0d",
                     kw, got_full.size() - row_base, n);
        end
        for (int b = 0; b < n && row_base + b < got_full.size(); b++) begin
            g = row_base + b;
            check_bit($sformatf("out_is_config beat %0d", b), got_cfg[g], exp_cfg[b]);
            check_bit($sformatf("out_cin_last beat %0d", b), got_last[g], exp_last[b]);
            check_mask($sformatf("out_mask_full beat %0d", b), got_full[g], exp_full[b]);
            if (!exp_cfg[b])
                check_mask($sformatf("out_mask_partial beat %0d", b), got_part[g], exp_part[b]);
            for (int m = 0; m < `MEMBERS && exp_cls[b] >= 0; m++)
                check_clr($sformatf("out_clr[%0d] beat %0d", m, b), got_clr[g][m], exp_cls[b]);
        end
    endtask

    task automatic run_row(input int kw, w, cins);
        prepare_row(kw, w, cins);
        apb_write(12'h00c, 1, 1'b0);
        finish_row(kw);
    endtask

    task automatic test_registers();
        apb_read(12'h000, 1);          // reset values
        apb_read(12'h004, 1);
        apb_read(12'h008, 1);
        apb_read(12'h00c, 0);
        apb_write(12'h000, 4, 1'b1);   // even kernel
        apb_write(12'h000, 9, 1'b1);   // wider than the lookup tables
        apb_write(12'h010, 3, 1'b1);   // unmapped
        apb_read(12'h000, 1);
        prepare_row(5, 4, 2);
        apb_read(12'h000, 5);
        apb_read(12'h004, 4);
        apb_read(12'h008, 2);
        apb_write(12'h00c, 1, 1'b0);
        apb_read(12'h00c, 1);
        apb_write(12'h00c, 1, 1'b1);   // second start while the row runs
        finish_row(5);
    endtask

    task automatic test_unused_members();
        int c;
        run_row(7, 8, 2);
        for (int b = 1; b < 17; b++) begin
            c = (b - 1) / 2;
            for (int m = (`MEMBERS / 7) * 7; m < `MEMBERS; m++) begin
                check_bit($sformatf("unused out_mask_partial[%0d] beat %0d", m, b),
                          got_part[row_base + b][m], 1'b0);
                if (c == 7)
                    check_bit($sformatf("unused out_mask_full[%0d] beat %0d", m, b),
                              got_full[row_base + b][m], 1'b0);
            end
        end
    endtask

    initial begin
        reset    = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        row_base = 0;
        fork
            collect();
        join_none
        repeat (3) @(posedge aclk);
        reset <= 1'b0;
        test_registers();
        run_row(1, 4, 2);    // kw = 1 passes everything
        run_row(3, 6, 1);
        run_row(5, 10, 3);   // back to back rows
        run_row(7, 10, 3);
        stall_en = 1'b1;
        run_row(5, 10, 3);
        test_unused_members();
        $display("%0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
